//--- branch_unit.f
verilog/br_pkg.sv
verilog/br_flag_gen.sv
verilog/br_stage_buffer.sv
verilog/br_resolve.sv
verilog/br_result_out.sv
verilog/branch_unit.sv
tb/branch_unit_assertions.sv
tb/branch_unit_tb.sv

//--- Bender.yml
package:
  name: branch_unit

sources:
  - verilog/br_pkg.sv
  - verilog/br_flag_gen.sv
  - verilog/br_stage_buffer.sv
  - verilog/br_resolve.sv
  - verilog/br_result_out.sv
  - verilog/branch_unit.sv
  - target: test
    files:
      - tb/branch_unit_assertions.sv
      - tb/branch_unit_tb.sv

//--- tb/branch_unit_tb.sv
`timescale 1ns/1ns

module branch_unit_tb;

    localparam int num_cycles     = 400;
    localparam int timeout_cycles = num_cycles + 20;
    localparam int drive_delay    = 10;

    // one expected output of the DUT, tagged with the cycle it was driven in.
    typedef struct packed {
        int                 cyc;
        logic               valid;
        logic               branch;
        br_pkg::br_result_t res;
        br_pkg::br_update_t upd;
    } expect_t;

    logic               clk;
    logic               reset;
    logic               issue_valid;
    br_pkg::br_issue_t  issue;
    logic               result_valid;
    br_pkg::br_result_t result;
    logic               update_valid;
    br_pkg::br_update_t update;

    int      cycle;
    logic    checking;
    expect_t expected[$];
    expect_t due;

    branch_unit uut (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result),
        .update_valid (update_valid),
        .update       (update)
    );

    always #50 clk = ~clk;

    // ##############################
    // reference model
    // ##############################

    function automatic expect_t predict(input br_pkg::br_issue_t ins);
        expect_t     e;
        logic        taken;
        logic [31:0] target;
        logic [31:0] next_pc;
        e = '0;
        next_pc = ins.pc + 32'd4;
        taken = 1'b1;
        if (ins.op == br_pkg::br_op_branch) begin
            case (ins.cond)
                br_pkg::cond_eq:  taken = (ins.src1 == ins.src2);
                br_pkg::cond_ne:  taken = (ins.src1 != ins.src2);
                br_pkg::cond_lt:  taken = ($signed(ins.src1) < $signed(ins.src2));
                br_pkg::cond_ge:  taken = ($signed(ins.src1) >= $signed(ins.src2));
                br_pkg::cond_ltu: taken = (ins.src1 < ins.src2);
                br_pkg::cond_geu: taken = (ins.src1 >= ins.src2);
                default:          taken = 1'b0;  // 010 and 011 never branch.
            endcase
            target = ins.pc + ins.imm;
        end else if (ins.op == br_pkg::br_op_jal) begin
            target = ins.pc + ins.imm;
        end else begin
            target = (ins.src1 + ins.imm) & ~32'd1;
        end
        e.branch          = (ins.op == br_pkg::br_op_branch);
        e.res.inst_num    = ins.inst_num;
        e.res.taken       = taken;
        e.res.redirect    = (taken != (ins.pred_taken && ins.btb_hit));
        e.res.redirect_pc = taken ? target : next_pc;
        e.res.link_we     = !e.branch;
        e.res.link_phy    = e.branch ? '0 : ins.dest_phy;
        e.res.link_data   = e.branch ? '0 : next_pc;
        e.upd.pc          = ins.pc;
        e.upd.taken       = taken;
        return e;
    endfunction

    // ##############################
    // stimulus
    // ##############################

    // about half the operands sit on the signed and unsigned boundaries.
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $urandom;
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'hffff_ffff;
            default: return r;
        endcase
    endfunction

    function automatic br_pkg::br_issue_t make_issue(input int n);
        br_pkg::br_issue_t ins;
        int                kind;
        logic [2:0]        code;
        logic [31:0]       r;
        ins = '0;
        kind = $urandom_range(0, 9);
        if (kind < 6) begin
            ins.op = br_pkg::br_op_branch;
        end else if (kind < 8) begin
            ins.op = br_pkg::br_op_jal;
        end else begin
            ins.op = br_pkg::br_op_jalr;
        end
        code = $urandom_range(0, 7);
        ins.cond       = br_pkg::br_cond_e'(code);
        ins.pred_taken = $urandom_range(0, 1);
        ins.btb_hit    = $urandom_range(0, 1);
        ins.dest_phy   = $urandom_range(0, 255);
        ins.inst_num   = n;
        r = $urandom;
        ins.pc = {r[31:2], 2'b00};
        r = $urandom;
        ins.imm = (ins.op == br_pkg::br_op_jalr) ? r : {r[31:1], 1'b0};  // pc offsets are even.
        ins.src1 = pick_operand();
        if ($urandom_range(0, 3) == 0) begin
            ins.src2 = ins.src1;
        end else begin
            ins.src2 = pick_operand();
        end
        return ins;
    endfunction

    task automatic drive_cycle(input int n);
        expect_t e;
        issue       = make_issue(n);
        issue_valid = ($urandom_range(0, 9) < 8);
        e       = predict(issue);
        e.cyc   = cycle;
        e.valid = issue_valid;
        expected.push_back(e);
    endtask

    // ##############################
    // checks
    // ##############################

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error.");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s at cycle %0d: got %h expected %h", name, cycle, got, exp);
            abort_run();
        end
    endtask

    task automatic check_result(input br_pkg::br_result_t got, input br_pkg::br_result_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED result at cycle %0d: got %h expected %h", cycle, got, exp);
            abort_run();
        end
    endtask

    task automatic check_update(input br_pkg::br_update_t got, input br_pkg::br_update_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED update at cycle %0d: got %h expected %h", cycle, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("ERROR: the run did not finish within %0d cycles.", timeout_cycles);
            abort_run();
        end
    end

    always @(posedge clk) begin
        if (uut.u_assertions.fail_count != 0) begin
            $display("ERROR: an assertion on the DUT outputs failed at cycle %0d.", cycle);
            abort_run();
        end
    end

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (checking) begin
            if (expected.size() != 0 && expected[0].cyc + 2 == cycle) begin
                due = expected.pop_front();
                check_flag("result_valid", result_valid, due.valid);
                check_flag("update_valid", update_valid, due.valid & due.branch);
                if (due.valid) begin
                    check_result(result, due.res);
                end
                if (due.valid && due.branch) begin
                    check_update(update, due.upd);
                end
            end else begin
                check_flag("result_valid", result_valid, 1'b0);
                check_flag("update_valid", update_valid, 1'b0);
            end
        end
    end

    initial begin
        void'($urandom(6));
        clk         = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        cycle       = 0;
        checking    = 1'b0;

        repeat (4) @(posedge clk);
        #drive_delay;
        reset    = 1'b0;
        checking = 1'b1;

        for (int i = 0; i < num_cycles; i++) begin
            drive_cycle(i);
            @(posedge clk);
            #drive_delay;
        end
        issue_valid = 1'b0;

        while (expected.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- tb/branch_unit_assertions.sv
`timescale 1ns/1ns

module branch_unit_assertions (
    input logic               clk,
    input logic               reset,
    input logic               result_valid,
    input br_pkg::br_result_t result,
    input logic               update_valid
);

    int fail_count = 0;

    // ##############################
    // output rules
    // ##############################

    // a predictor update always comes with its branch result.
    update_with_result: assert property (
        @(posedge clk) disable iff (reset) update_valid |-> result_valid
    ) else begin
        $error("update_valid is set without result_valid.");
        fail_count++;
    end

    link_with_result: assert property (
        @(posedge clk) disable iff (reset) result.link_we |-> result_valid
    ) else begin
        $error("link_we is set without result_valid.");
        fail_count++;
    end

    redirect_aligned: assert property (
        @(posedge clk) disable iff (reset) result_valid |-> (result.redirect_pc[0] == 1'b0)
    ) else begin
        $error("redirect_pc has bit 0 set.");  // targets are at least halfword aligned.
        fail_count++;
    end

endmodule

bind branch_unit branch_unit_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .result_valid (result_valid),
    .result       (result),
    .update_valid (update_valid)
);

//--- verilog/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue_valid,
    input  br_pkg::br_issue_t  issue,
    output logic               result_valid,
    output br_pkg::br_result_t result,
    output logic               update_valid,
    output br_pkg::br_update_t update
);

    br_pkg::br_flags_t  flags;
    logic               staged_valid;
    br_pkg::br_staged_t staged;
    logic               res_valid;
    br_pkg::br_result_t res;
    logic               is_branch;
    br_pkg::br_update_t upd;

    br_flag_gen u_flag_gen (
        .issue (issue),
        .flags (flags)
    );

    br_stage_buffer u_stage_buffer (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (issue_valid),
        .issue        (issue),
        .flags        (flags),
        .staged_valid (staged_valid),
        .staged       (staged)
    );

    br_resolve u_resolve (
        .staged_valid (staged_valid),
        .staged       (staged),
        .res_valid    (res_valid),
        .res          (res),
        .is_branch    (is_branch),
        .upd          (upd)
    );

    br_result_out u_result_out (
        .clk          (clk),
        .reset        (reset),
        .res_valid    (res_valid),
        .res          (res),
        .is_branch    (is_branch),
        .upd_in       (upd),
        .result_valid (result_valid),
        .result       (result),
        .update_valid (update_valid),
        .update       (update)
    );

endmodule

//--- verilog/br_result_out.sv
`timescale 1ns/1ns

module br_result_out (
    input  logic               clk,
    input  logic               reset,
    input  logic               res_valid,
    input  br_pkg::br_result_t res,
    input  logic               is_branch,
    input  br_pkg::br_update_t upd_in,
    output logic               result_valid,
    output br_pkg::br_result_t result,
    output logic               update_valid,
    output br_pkg::br_update_t update
);

    // ##############################
    // result register
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= res_valid;
            result       <= res;
        end
    end

    // ##############################
    // predictor update
    // ##############################

    // jumps are always taken, so only conditional branches train the predictor.
    always_ff @(posedge clk) begin
        if (reset) begin
            update_valid <= 1'b0;
            update       <= '0;
        end else begin
            update_valid <= res_valid & is_branch;
            update       <= upd_in;  // same cycle as its result.
        end
    end

endmodule

//--- verilog/br_resolve.sv
`timescale 1ns/1ns

module br_resolve (
    input  logic               staged_valid,
    input  br_pkg::br_staged_t staged,
    output logic               res_valid,
    output br_pkg::br_result_t res,
    output logic               is_branch,
    output br_pkg::br_update_t upd
);

    logic                          cond_taken;
    logic                          taken;
    logic                          pred_eff;
    logic                          is_jump;
    logic [br_pkg::data_width-1:0] target_base;
    logic [br_pkg::data_width-1:0] target;
    logic [br_pkg::data_width-1:0] fall_through;

    // ##############################
    // condition
    // ##############################

    always_comb begin
        case (staged.issue.cond)
            br_pkg::cond_eq:  cond_taken = staged.flags.zero;
            br_pkg::cond_ne:  cond_taken = ~staged.flags.zero;
            br_pkg::cond_lt:  cond_taken = staged.flags.negative ^ staged.flags.overflow;
            br_pkg::cond_ge:  cond_taken = ~(staged.flags.negative ^ staged.flags.overflow);
            br_pkg::cond_ltu: cond_taken = ~staged.flags.carry;
            br_pkg::cond_geu: cond_taken = staged.flags.carry;
            default:          cond_taken = 1'b0;  // reserved funct3 never branches.
        endcase
    end

    assign is_branch = (staged.issue.op == br_pkg::br_op_branch);
    assign is_jump   = ~is_branch;
    assign taken     = is_jump | cond_taken;

    // ##############################
    // target and link
    // ##############################

    // jalr adds to the register, everything else to the pc.
    assign target_base  = (staged.issue.op == br_pkg::br_op_jalr) ? staged.issue.src1
                                                                  : staged.issue.pc;
    assign target       = target_base + staged.issue.imm;
    assign fall_through = staged.issue.pc + br_pkg::inst_bytes;

    // the front end only followed a taken guess if it also had a target.
    assign pred_eff = staged.issue.pred_taken & staged.issue.btb_hit;

    always_comb begin
        res.inst_num = staged.issue.inst_num;
        res.taken    = taken;
        res.redirect = (taken != pred_eff);

        if (taken) begin
            res.redirect_pc = {target[br_pkg::data_width-1:1], 1'b0};
        end else begin
            res.redirect_pc = fall_through;
        end

        res.link_we   = staged_valid & is_jump;  // an empty slot writes no register.
        res.link_phy  = is_jump ? staged.issue.dest_phy : '0;
        res.link_data = is_jump ? fall_through : '0;
    end

    assign res_valid = staged_valid;

    assign upd.pc    = staged.issue.pc;
    assign upd.taken = taken;

endmodule

//--- verilog/br_stage_buffer.sv
`timescale 1ns/1ns

module br_stage_buffer (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  br_pkg::br_issue_t  issue,
    input  br_pkg::br_flags_t  flags,
    output logic               staged_valid,
    output br_pkg::br_staged_t staged
);

    // holds one issued instruction between the compare and resolution.
    // there is no stall, so a new entry is taken on every edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            staged_valid <= 1'b0;
            staged       <= '0;
        end else begin
            staged_valid <= in_valid;
            staged.issue <= issue;
            staged.flags <= flags;  // flags ride with their instruction.
        end
    end

endmodule

//--- verilog/br_flag_gen.sv
`timescale 1ns/1ns

module br_flag_gen (
    input  br_pkg::br_issue_t issue,
    output br_pkg::br_flags_t flags
);

    // ##############################
    // operand compare
    // ##############################

    // one extra bit on top catches the borrow out of the msb.
    logic [br_pkg::data_width:0]   diff;
    logic [br_pkg::data_width-1:0] diff_lo;
    logic                          sign1;
    logic                          sign2;

    assign diff = {1'b0, issue.src1} - {1'b0, issue.src2};
    assign diff_lo = diff[br_pkg::data_width-1:0];

    assign sign1 = issue.src1[br_pkg::data_width-1];
    assign sign2 = issue.src2[br_pkg::data_width-1];

    always_comb begin
        flags.negative = diff_lo[br_pkg::data_width-1];
        flags.zero     = (diff_lo == '0);

        // a subtraction overflows only when the operand signs differ
        // and the result sign does not match the minuend.
        flags.overflow = (sign1 != sign2) && (diff_lo[br_pkg::data_width-1] != sign1);

        flags.carry    = ~diff[br_pkg::data_width];  // no borrow means src1 >= src2 unsigned.
    end

endmodule

//--- verilog/br_pkg.sv
package br_pkg;

    // ##############################
    // widths
    // ##############################

    localparam int data_width = 32;  // register data and pc.
    localparam int phy_width  = 8;   // physical register tag.
    localparam int tag_width  = 32;  // instruction sequence number.

    // size of one uncompressed instruction, used for fall-through and link.
    localparam logic [data_width-1:0] inst_bytes = 32'd4;

    // ##############################
    // encodings
    // ##############################

    typedef enum logic [1:0] {
        br_op_branch = 2'd0,
        br_op_jal    = 2'd1,
        br_op_jalr   = 2'd2
    } br_op_e;

    // funct3 of the conditional branches. 010 and 011 are reserved.
    typedef enum logic [2:0] {
        cond_eq  = 3'b000,
        cond_ne  = 3'b001,
        cond_lt  = 3'b100,
        cond_ge  = 3'b101,
        cond_ltu = 3'b110,
        cond_geu = 3'b111
    } br_cond_e;

    // ##############################
    // payloads
    // ##############################

    typedef struct packed {
        br_op_e                op;
        br_cond_e              cond;
        logic                  pred_taken;  // predicted direction.
        logic                  btb_hit;     // predictor supplied a target.
        logic [phy_width-1:0]  dest_phy;
        logic [tag_width-1:0]  inst_num;
        logic [data_width-1:0] pc;
        logic [data_width-1:0] imm;
        logic [data_width-1:0] src1;
        logic [data_width-1:0] src2;
    } br_issue_t;

    // flags of src1 - src2. carry is set when there is no borrow.
    typedef struct packed {
        logic negative;
        logic zero;
        logic overflow;
        logic carry;
    } br_flags_t;

    typedef struct packed {
        br_issue_t issue;
        br_flags_t flags;
    } br_staged_t;

    typedef struct packed {
        logic [tag_width-1:0]  inst_num;
        logic                  taken;
        logic                  redirect;
        logic [data_width-1:0] redirect_pc;
        logic                  link_we;
        logic [phy_width-1:0]  link_phy;
        logic [data_width-1:0] link_data;
    } br_result_t;

    typedef struct packed {
        logic [data_width-1:0] pc;
        logic                  taken;
    } br_update_t;

endpackage
